// ==== axi_ar_burst_split.sv ====
// AR burst splitter: takes AXI read requests and queues one entry per beat for the master
`timescale 1ns/1ps

module axi_ar_burst_split (
	input  logic                  i_axi_clk,
	input  logic                  i_reset,
	// AXI read address channel
	input  logic                  i_axi_arvalid,
	output logic                  o_axi_arready,
	input  axi_wb_rd_pkg::id_t    i_axi_arid,
	input  axi_wb_rd_pkg::addr_t  i_axi_araddr,
	input  axi_wb_rd_pkg::len_t   i_axi_arlen,
	input  axi_wb_rd_pkg::burst_t i_axi_arburst,
	// Head of the request queue
	input  logic                  i_req_pop,
	output logic                  o_req_valid,
	output axi_wb_rd_pkg::id_t    o_req_id,
	output axi_wb_rd_pkg::addr_t  o_req_addr,
	output logic                  o_req_last
);
	import axi_wb_rd_pkg::*;

	split_state_t r_state;
	// Latched burst being walked
	id_t          r_id;
	addr_t        r_addr;
	len_t         r_cnt;
	logic         r_incr;
	// Request queue storage and pointers
	id_t          r_mem_id   [FIFO_DEPTH];
	addr_t        r_mem_addr [FIFO_DEPTH];
	logic         r_mem_last [FIFO_DEPTH];
	ptr_t         r_head;
	ptr_t         r_tail;
	room_t        r_fill;
	logic         w_full;
	logic         w_accept;
	logic         w_push;

	////////////////////
	// Queue flags
	////////////////////

	assign w_full   = (r_fill == room_t'(FIFO_DEPTH));
	assign w_accept = i_axi_arvalid && o_axi_arready;
	// One beat per cycle while there is space
	assign w_push   = (r_state == SPLIT_FILL) && !w_full;

	// Only take a new burst when idle and not full
	assign o_axi_arready = (r_state == SPLIT_IDLE) && !w_full;
	assign o_req_valid   = (r_fill != '0);
	assign o_req_id      = r_mem_id[r_head];
	assign o_req_addr    = r_mem_addr[r_head];
	assign o_req_last    = r_mem_last[r_head];

	////////////////////
	// Burst walker
	////////////////////

	always_ff @(posedge i_axi_clk)
	begin
		if (i_reset)
			r_state <= SPLIT_IDLE;
		else if (w_accept)
			r_state <= SPLIT_FILL;
		else if (w_push && (r_cnt == '0))
			r_state <= SPLIT_IDLE;
	end

	// Burst payload and beat walk
	always_ff @(posedge i_axi_clk)
	begin
		if (w_accept)
		begin
			r_id   <= i_axi_arid;
			r_addr <= i_axi_araddr;
			r_cnt  <= i_axi_arlen;
			// FIXED and WRAP both hold the address
			r_incr <= (i_axi_arburst == BURST_INCR);
		end
		else if (w_push)
		begin
			r_addr <= r_addr + {{(ADDR_W-1){1'b0}}, r_incr};
			r_cnt  <= r_cnt - 8'd1;
		end
	end

	////////////////////
	// Request queue
	////////////////////

	always_ff @(posedge i_axi_clk)
	begin
		if (w_push)
		begin
			r_mem_id[r_tail]   <= r_id;
			r_mem_addr[r_tail] <= r_addr;
			// Count at zero marks the final beat
			r_mem_last[r_tail] <= (r_cnt == '0);
		end
	end

	always_ff @(posedge i_axi_clk)
	begin
		if (i_reset)
		begin
			r_head <= '0;
			r_tail <= '0;
			r_fill <= '0;
		end
		else
		begin
			if (w_push)
				r_tail <= r_tail + 1'b1;
			if (i_req_pop)
				r_head <= r_head + 1'b1;
			// Occupancy tracks push minus pop
			case ({w_push, i_req_pop})
				2'b10:   r_fill <= r_fill + room_t'(1);
				2'b01:   r_fill <= r_fill - room_t'(1);
				default: r_fill <= r_fill;
			endcase
		end
	end

	// A push never lands on the live head entry
	a_no_push_full: assert property (@(posedge i_axi_clk) disable iff (i_reset)
		(w_push && (r_fill != '0)) |-> (r_tail != r_head));
	// Master only pops an entry that is there
	a_pop_valid: assert property (@(posedge i_axi_clk) disable iff (i_reset)
		i_req_pop |-> o_req_valid);

endmodule

// ==== axi_r_return.sv ====
// AXI R return queue: buffers terminated beats and presents them on the read-data channel
`timescale 1ns/1ps

module axi_r_return (
	input  logic                 i_axi_clk,
	input  logic                 i_reset,
	// Beats from the Wishbone master
	input  logic                 i_beat_wr,
	input  axi_wb_rd_pkg::id_t   i_beat_id,
	input  logic                 i_beat_last,
	input  axi_wb_rd_pkg::data_t i_beat_data,
	input  axi_wb_rd_pkg::resp_t i_beat_resp,
	output axi_wb_rd_pkg::room_t o_room,
	// AXI read data channel
	output logic                 o_axi_rvalid,
	input  logic                 i_axi_rready,
	output axi_wb_rd_pkg::id_t   o_axi_rid,
	output axi_wb_rd_pkg::data_t o_axi_rdata,
	output axi_wb_rd_pkg::resp_t o_axi_rresp,
	output logic                 o_axi_rlast
);
	import axi_wb_rd_pkg::*;

	// Response queue storage
	id_t   r_mem_id   [FIFO_DEPTH];
	logic  r_mem_last [FIFO_DEPTH];
	data_t r_mem_data [FIFO_DEPTH];
	resp_t r_mem_resp [FIFO_DEPTH];
	ptr_t  r_wr;
	ptr_t  r_rd;
	room_t r_fill;
	logic  w_load;

	// Refill the output stage when empty or being taken
	assign w_load = (r_fill != '0) && (!o_axi_rvalid || i_axi_rready);
	// Output stage is extra, only the queue counts
	assign o_room = room_t'(FIFO_DEPTH) - r_fill;

	////////////////////
	// Queue
	////////////////////

	always_ff @(posedge i_axi_clk)
	begin
		if (i_beat_wr)
		begin
			r_mem_id[r_wr]   <= i_beat_id;
			r_mem_last[r_wr] <= i_beat_last;
			r_mem_data[r_wr] <= i_beat_data;
			r_mem_resp[r_wr] <= i_beat_resp;
		end
	end

	always_ff @(posedge i_axi_clk)
	begin
		if (i_reset)
		begin
			r_wr   <= '0;
			r_rd   <= '0;
			r_fill <= '0;
		end
		else
		begin
			if (i_beat_wr)
				r_wr <= r_wr + 1'b1;
			if (w_load)
				r_rd <= r_rd + 1'b1;
			case ({i_beat_wr, w_load})
				2'b10:   r_fill <= r_fill + room_t'(1);
				2'b01:   r_fill <= r_fill - room_t'(1);
				default: r_fill <= r_fill;
			endcase
		end
	end

	////////////////////
	// R output stage
	////////////////////

	always_ff @(posedge i_axi_clk)
	begin
		if (i_reset)
			o_axi_rvalid <= 1'b0;
		else if (w_load)
			o_axi_rvalid <= 1'b1;
		else if (i_axi_rready)
			o_axi_rvalid <= 1'b0;
	end

	// Payload moves only on a load
	always_ff @(posedge i_axi_clk)
	begin
		if (w_load)
		begin
			o_axi_rid   <= r_mem_id[r_rd];
			o_axi_rlast <= r_mem_last[r_rd];
			o_axi_rdata <= r_mem_data[r_rd];
			o_axi_rresp <= r_mem_resp[r_rd];
		end
	end

	// Stalled beat stays put
	a_r_stable: assert property (@(posedge i_axi_clk) disable iff (i_reset)
		(o_axi_rvalid && !i_axi_rready) |=> (o_axi_rvalid && $stable(o_axi_rdata)
		&& $stable(o_axi_rid) && $stable(o_axi_rlast) && $stable(o_axi_rresp)));
	// Master's room check keeps writes off a full queue
	a_no_overflow: assert property (@(posedge i_axi_clk) disable iff (i_reset)
		i_beat_wr |-> (r_fill != room_t'(FIFO_DEPTH)));

endmodule

// ==== axi_wb_rd_bridge.f ====
axi_wb_rd_pkg.sv
axi_ar_burst_split.sv
wb_rd_master.sv
axi_r_return.sv
axi_wb_rd_bridge.sv
tb_axi_wb_rd_bridge.sv

// ==== axi_wb_rd_bridge.sv ====
// AXI read to Wishbone bridge top: splitter, Wishbone master and R return queue
`timescale 1ns/1ps

module axi_wb_rd_bridge (
	input  logic                  i_axi_clk,
	input  logic                  i_axi_reset_n,
	// AXI read address channel
	input  logic                  i_axi_arvalid,
	output logic                  o_axi_arready,
	input  axi_wb_rd_pkg::id_t    i_axi_arid,
	input  axi_wb_rd_pkg::addr_t  i_axi_araddr,
	input  axi_wb_rd_pkg::len_t   i_axi_arlen,
	input  axi_wb_rd_pkg::burst_t i_axi_arburst,
	// AXI read data channel
	output logic                  o_axi_rvalid,
	input  logic                  i_axi_rready,
	output axi_wb_rd_pkg::id_t    o_axi_rid,
	output axi_wb_rd_pkg::data_t  o_axi_rdata,
	output axi_wb_rd_pkg::resp_t  o_axi_rresp,
	output logic                  o_axi_rlast,
	// Wishbone B4 pipelined
	output logic                  o_wb_cyc,
	output logic                  o_wb_stb,
	output axi_wb_rd_pkg::addr_t  o_wb_addr,
	input  logic                  i_wb_stall,
	input  logic                  i_wb_ack,
	input  logic                  i_wb_err,
	input  axi_wb_rd_pkg::data_t  i_wb_data
);
	import axi_wb_rd_pkg::*;

	logic  w_reset;
	// Request queue head
	logic  w_req_valid;
	logic  w_req_pop;
	id_t   w_req_id;
	addr_t w_req_addr;
	logic  w_req_last;
	// Returning beats
	logic  w_beat_wr;
	id_t   w_beat_id;
	logic  w_beat_last;
	data_t w_beat_data;
	resp_t w_beat_resp;
	room_t w_room;

	// Active high reset for all blocks
	assign w_reset = !i_axi_reset_n;

	////////////////////
	// Blocks
	////////////////////

	axi_ar_burst_split u_split (
		.i_axi_clk     (i_axi_clk),
		.i_reset       (w_reset),
		.i_axi_arvalid (i_axi_arvalid),
		.o_axi_arready (o_axi_arready),
		.i_axi_arid    (i_axi_arid),
		.i_axi_araddr  (i_axi_araddr),
		.i_axi_arlen   (i_axi_arlen),
		.i_axi_arburst (i_axi_arburst),
		.i_req_pop     (w_req_pop),
		.o_req_valid   (w_req_valid),
		.o_req_id      (w_req_id),
		.o_req_addr    (w_req_addr),
		.o_req_last    (w_req_last)
	);

	wb_rd_master u_master (
		.i_axi_clk   (i_axi_clk),
		.i_reset     (w_reset),
		.i_req_valid (w_req_valid),
		.i_req_id    (w_req_id),
		.i_req_addr  (w_req_addr),
		.i_req_last  (w_req_last),
		.o_req_pop   (w_req_pop),
		.i_room      (w_room),
		.o_wb_cyc    (o_wb_cyc),
		.o_wb_stb    (o_wb_stb),
		.o_wb_addr   (o_wb_addr),
		.i_wb_stall  (i_wb_stall),
		.i_wb_ack    (i_wb_ack),
		.i_wb_err    (i_wb_err),
		.i_wb_data   (i_wb_data),
		.o_beat_wr   (w_beat_wr),
		.o_beat_id   (w_beat_id),
		.o_beat_last (w_beat_last),
		.o_beat_data (w_beat_data),
		.o_beat_resp (w_beat_resp)
	);

	axi_r_return u_return (
		.i_axi_clk    (i_axi_clk),
		.i_reset      (w_reset),
		.i_beat_wr    (w_beat_wr),
		.i_beat_id    (w_beat_id),
		.i_beat_last  (w_beat_last),
		.i_beat_data  (w_beat_data),
		.i_beat_resp  (w_beat_resp),
		.o_room       (w_room),
		.o_axi_rvalid (o_axi_rvalid),
		.i_axi_rready (i_axi_rready),
		.o_axi_rid    (o_axi_rid),
		.o_axi_rdata  (o_axi_rdata),
		.o_axi_rresp  (o_axi_rresp),
		.o_axi_rlast  (o_axi_rlast)
	);

endmodule

// ==== axi_wb_rd_pkg.sv ====
// Shared widths, queue depth, data types and state encodings of the AXI to Wishbone read bridge
package axi_wb_rd_pkg;

	////////////////////
	// Widths and depths
	////////////////////

	// AXI ID width
	localparam int ID_W       = 4;
	// Word address, no byte lanes
	localparam int ADDR_W     = 28;
	localparam int DATA_W     = 32;
	// Log2 of every queue depth
	localparam int LGFIFO     = 4;
	localparam int FIFO_DEPTH = 1 << LGFIFO;

	////////////////////
	// Vector types
	////////////////////

	typedef logic [ID_W-1:0]   id_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	// Burst length minus one, as on arlen
	typedef logic [7:0]        len_t;
	typedef logic [LGFIFO-1:0] ptr_t;
	// One extra bit so a count can reach FIFO_DEPTH
	typedef logic [LGFIFO:0]   room_t;

	////////////////////
	// Encodings
	////////////////////

	// AXI arburst codes; WRAP walks like FIXED here
	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} burst_t;

	// AXI rresp codes in use
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_t;

	typedef enum logic {SPLIT_IDLE, SPLIT_FILL} split_state_t;
	typedef enum logic {WB_IDLE, WB_BUS} wb_state_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the bridge testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_axi_wb_rd_bridge --Mdir obj_dir -o tb_sim \
	-f axi_wb_rd_bridge.f \
	&& ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Finished with errors" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation PASSED"

// ==== tb_axi_wb_rd_bridge.sv ====
// Testbench for the AXI read to Wishbone bridge, with a random-latency Wishbone slave model
`timescale 1ns/1ps

module tb_axi_wb_rd_bridge;
	import axi_wb_rd_pkg::*;

	localparam int N_ROWS     = 10;
	localparam int AR_WAIT    = 5000;
	localparam int DRAIN_WAIT = 5000;

	// One AR request and what it should give back
	typedef struct packed {
		id_t        id;
		addr_t      addr;
		len_t       len;
		burst_t     burst;
		logic [8:0] n_err;
		logic       drain;
	} row_t;

	////////////////////
	// Stimulus table
	////////////////////

	// id, word address, arlen, burst, SLVERR beats, wait for drain
	row_t tbl [N_ROWS] = '{
		'{4'h1, 28'h0000100, 8'd0,   BURST_INCR,  9'd0, 1'b1},
		'{4'h2, 28'h0000200, 8'd15,  BURST_INCR,  9'd0, 1'b1},
		'{4'h3, 28'h0000345, 8'd7,   BURST_FIXED, 9'd0, 1'b1},
		'{4'h4, 28'h00004e8, 8'd11,  BURST_INCR,  9'd1, 1'b1},
		'{4'h5, 28'h00005ee, 8'd3,   BURST_FIXED, 9'd4, 1'b1},
		// Back to back from here on
		'{4'h6, 28'h0001000, 8'd31,  BURST_INCR,  9'd0, 1'b0},
		'{4'h7, 28'h00020f0, 8'd63,  BURST_INCR,  9'd0, 1'b0},
		'{4'h8, 28'h0003000, 8'd255, BURST_INCR,  9'd1, 1'b0},
		'{4'h9, 28'h0004abc, 8'd0,   BURST_FIXED, 9'd0, 1'b0},
		'{4'ha, 28'h00050e0, 8'd20,  BURST_INCR,  9'd1, 1'b1}
	};

	// DUT ports
	logic   i_axi_clk;
	logic   i_axi_reset_n;
	logic   i_axi_arvalid;
	logic   o_axi_arready;
	id_t    i_axi_arid;
	addr_t  i_axi_araddr;
	len_t   i_axi_arlen;
	burst_t i_axi_arburst;
	logic   o_axi_rvalid;
	logic   i_axi_rready = 1'b0;
	id_t    o_axi_rid;
	data_t  o_axi_rdata;
	resp_t  o_axi_rresp;
	logic   o_axi_rlast;
	logic   o_wb_cyc;
	logic   o_wb_stb;
	addr_t  o_wb_addr;
	logic   i_wb_stall = 1'b0;
	logic   i_wb_ack   = 1'b0;
	logic   i_wb_err   = 1'b0;
	data_t  i_wb_data  = '0;

	// Scoreboard in request order
	id_t   exp_id_q   [$];
	data_t exp_data_q [$];
	resp_t exp_resp_q [$];
	logic  exp_last_q [$];
	// Addresses strobed but not yet answered by the slave
	addr_t pend_q     [$];
	addr_t s_addr;
	logic  s_b0;
	logic  s_b1;
	logic [31:0] r_lfsr = 32'hebf4;
	// Per-burst tally on the R side
	int    r_row   = 0;
	int    r_errs  = 0;

	axi_wb_rd_bridge dut (.*);

	initial
	begin
		i_axi_clk = 1'b0;
		forever #5 i_axi_clk = ~i_axi_clk;
	end

	////////////////////
	// Helpers
	////////////////////

	// Slave read data rule
	function automatic data_t wb_word(input addr_t a);
		return {{(DATA_W-ADDR_W){1'b0}}, a} ^ 32'h5a5a0000;
	endfunction

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic next_bit();
		logic fb;
		fb     = r_lfsr[31] ^ r_lfsr[21] ^ r_lfsr[1] ^ r_lfsr[0];
		r_lfsr = {r_lfsr[30:0], fb};
		return fb;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_id(input id_t got, input id_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("Error at %0t: %s got %0h expected %0h", $time, what, got, exp));
	endtask

	task automatic check_data(input data_t got, input data_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("Error at %0t: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_resp(input resp_t got, input resp_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("Error at %0t: %s got %s expected %s", $time, what,
				got.name(), exp.name()));
	endtask

	task automatic check_last(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_run($sformatf("Error at %0t: %s got %b expected %b", $time, what, got, exp));
	endtask

	// Single control levels such as arready or cyc
	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_run($sformatf("Error at %0t: %s got %b expected %b", $time, what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			fail_run($sformatf("Error at %0t: %s got %0d expected %0d", $time, what, got, exp));
	endtask

	////////////////////
	// AR driver
	////////////////////

	task automatic issue_ar(input int idx);
		int    waited;
		addr_t a;
		waited = 0;
		@(posedge i_axi_clk);
		i_axi_arvalid <= 1'b1;
		i_axi_arid    <= tbl[idx].id;
		i_axi_araddr  <= tbl[idx].addr;
		i_axi_arlen   <= tbl[idx].len;
		i_axi_arburst <= tbl[idx].burst;
		@(posedge i_axi_clk);
		while (!o_axi_arready && waited < AR_WAIT)
		begin
			@(posedge i_axi_clk);
			waited++;
		end
		if (!o_axi_arready)
			fail_run($sformatf("Timed out waiting for arready on row %0d", idx));
		i_axi_arvalid <= 1'b0;
		// One expected beat per address walked
		a = tbl[idx].addr;
		for (int b = 0; b <= int'(tbl[idx].len); b++)
		begin
			exp_id_q.push_back(tbl[idx].id);
			exp_data_q.push_back(wb_word(a));
			if (a[7:0] == 8'hee)
				exp_resp_q.push_back(RESP_SLVERR);
			else
				exp_resp_q.push_back(RESP_OKAY);
			exp_last_q.push_back(b == int'(tbl[idx].len));
			// FIXED stays on one word
			if (tbl[idx].burst == BURST_INCR)
				a = a + 28'd1;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_id_q.size() != 0 && waited < DRAIN_WAIT)
		begin
			@(posedge i_axi_clk);
			waited++;
		end
		if (exp_id_q.size() != 0)
			fail_run($sformatf("Timed out with %0d R beats never returned", exp_id_q.size()));
	endtask

	////////////////////
	// Wishbone slave and rready
	////////////////////

	always @(posedge i_axi_clk)
	begin
		if (!i_axi_reset_n)
		begin
			i_wb_stall   <= 1'b0;
			i_wb_ack     <= 1'b0;
			i_wb_err     <= 1'b0;
			i_axi_rready <= 1'b0;
		end
		else
		begin
			// Strobe taken this edge
			if (o_wb_cyc && o_wb_stb && !i_wb_stall)
				pend_q.push_back(o_wb_addr);
			// Random ack delay with the oldest beat first
			if (pend_q.size() != 0 && next_bit())
			begin
				s_addr = pend_q.pop_front();
				i_wb_data <= wb_word(s_addr);
				i_wb_ack  <= (s_addr[7:0] != 8'hee);
				i_wb_err  <= (s_addr[7:0] == 8'hee);
			end
			else
			begin
				i_wb_ack <= 1'b0;
				i_wb_err <= 1'b0;
			end
			// Stall about a quarter of the time
			s_b0 = next_bit();
			s_b1 = next_bit();
			i_wb_stall   <= s_b0 & s_b1;
			i_axi_rready <= next_bit();
		end
	end

	////////////////////
	// R collector
	////////////////////

	always @(posedge i_axi_clk)
	begin
		if (i_axi_reset_n && o_axi_rvalid && i_axi_rready)
		begin
			if (exp_id_q.size() == 0)
				fail_run("An R beat arrived with nothing left in the scoreboard");
			else
			begin
				check_id(o_axi_rid, exp_id_q.pop_front(), "rid");
				check_data(o_axi_rdata, exp_data_q.pop_front(), "rdata");
				check_resp(o_axi_rresp, exp_resp_q.pop_front(), "rresp");
				check_last(o_axi_rlast, exp_last_q.pop_front(), "rlast");
				if (o_axi_rresp == RESP_SLVERR)
					r_errs++;
				// SLVERR tally of a closed burst against the table
				if (o_axi_rlast)
				begin
					check_count(r_errs, int'(tbl[r_row].n_err), "SLVERR beats in burst");
					r_row++;
					r_errs = 0;
				end
			end
		end
	end

	////////////////////
	// Main sequence
	////////////////////

	initial
	begin
		i_axi_reset_n = 1'b0;
		i_axi_arvalid = 1'b0;
		i_axi_arid    = '0;
		i_axi_araddr  = '0;
		i_axi_arlen   = '0;
		i_axi_arburst = BURST_FIXED;
		repeat (4) @(posedge i_axi_clk);
		i_axi_reset_n <= 1'b1;
		@(posedge i_axi_clk);
		// Quiet bus straight out of reset
		check_flag(o_axi_rvalid, 1'b0, "rvalid after reset");
		check_flag(o_wb_cyc, 1'b0, "cyc after reset");
		check_flag(o_wb_stb, 1'b0, "stb after reset");
		check_flag(o_axi_arready, 1'b1, "arready after reset");
		for (int i = 0; i < N_ROWS; i++)
		begin
			issue_ar(i);
			if (tbl[i].drain)
				wait_drain();
		end
		wait_drain();
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== wb_rd_master.sv ====
// Wishbone pipelined read master: strobes queued beats and tags each returning word
`timescale 1ns/1ps

module wb_rd_master (
	input  logic                 i_axi_clk,
	input  logic                 i_reset,
	// Request queue head
	input  logic                 i_req_valid,
	input  axi_wb_rd_pkg::id_t   i_req_id,
	input  axi_wb_rd_pkg::addr_t i_req_addr,
	input  logic                 i_req_last,
	output logic                 o_req_pop,
	// Free entries in the response queue
	input  axi_wb_rd_pkg::room_t i_room,
	// Wishbone B4 pipelined master
	output logic                 o_wb_cyc,
	output logic                 o_wb_stb,
	output axi_wb_rd_pkg::addr_t o_wb_addr,
	input  logic                 i_wb_stall,
	input  logic                 i_wb_ack,
	input  logic                 i_wb_err,
	input  axi_wb_rd_pkg::data_t i_wb_data,
	// Terminated beats to the return side
	output logic                 o_beat_wr,
	output axi_wb_rd_pkg::id_t   o_beat_id,
	output logic                 o_beat_last,
	output axi_wb_rd_pkg::data_t o_beat_data,
	output axi_wb_rd_pkg::resp_t o_beat_resp
);
	import axi_wb_rd_pkg::*;

	wb_state_t r_state;
	// Beats strobed but not yet acked
	room_t     r_inflight;
	room_t     w_inflight_nxt;
	// In-flight tag queue, same order as the strobes
	id_t       r_tag_id   [FIFO_DEPTH];
	logic      r_tag_last [FIFO_DEPTH];
	ptr_t      r_tag_wr;
	ptr_t      r_tag_rd;
	logic      w_room_ok;
	logic      w_accept;
	logic      w_term;

	////////////////////
	// Strobe control
	////////////////////

	// Keep every outstanding beat a slot in the response queue
	assign w_room_ok = (r_inflight < i_room);

	assign o_wb_cyc  = (r_state == WB_BUS);
	// Strobe while there is work and room
	assign o_wb_stb  = o_wb_cyc && i_req_valid && w_room_ok;
	// Head is held until the pop, so a stall keeps the address
	assign o_wb_addr = i_req_addr;
	assign w_accept  = o_wb_stb && !i_wb_stall;
	assign o_req_pop = w_accept;
	// Ack or err ends one beat
	assign w_term    = o_wb_cyc && (i_wb_ack || i_wb_err);

	always_comb
	begin
		w_inflight_nxt = r_inflight;
		if (w_accept && !w_term)
			w_inflight_nxt = r_inflight + room_t'(1);
		else if (!w_accept && w_term)
			w_inflight_nxt = r_inflight - room_t'(1);
	end

	////////////////////
	// Cycle FSM
	////////////////////

	always_ff @(posedge i_axi_clk)
	begin
		if (i_reset)
		begin
			r_state    <= WB_IDLE;
			r_inflight <= '0;
			r_tag_wr   <= '0;
			r_tag_rd   <= '0;
		end
		else
		begin
			r_inflight <= w_inflight_nxt;
			if (w_accept)
				r_tag_wr <= r_tag_wr + 1'b1;
			if (w_term)
				r_tag_rd <= r_tag_rd + 1'b1;
			case (r_state)
				WB_IDLE:
					// Open the cycle one clock after work shows up
					if (i_req_valid && w_room_ok)
						r_state <= WB_BUS;
				WB_BUS:
					// Close once nothing is strobing or owed
					if (!o_wb_stb && (w_inflight_nxt == '0))
						r_state <= WB_IDLE;
				default:
					r_state <= WB_IDLE;
			endcase
		end
	end

	// Tag storage
	always_ff @(posedge i_axi_clk)
	begin
		if (w_accept)
		begin
			r_tag_id[r_tag_wr]   <= i_req_id;
			r_tag_last[r_tag_wr] <= i_req_last;
		end
	end

	////////////////////
	// Beat output
	////////////////////

	assign o_beat_wr   = w_term;
	assign o_beat_id   = r_tag_id[r_tag_rd];
	assign o_beat_last = r_tag_last[r_tag_rd];
	assign o_beat_data = i_wb_data;
	// Err only fails its own beat
	assign o_beat_resp = i_wb_err ? RESP_SLVERR : RESP_OKAY;

	// Stalled strobe stays up with the same address
	a_stall_hold: assert property (@(posedge i_axi_clk) disable iff (i_reset)
		(o_wb_stb && i_wb_stall) |=> (o_wb_stb && $stable(o_wb_addr)));
	a_ack_err: assert property (@(posedge i_axi_clk) disable iff (i_reset)
		!(i_wb_ack && i_wb_err));
	// Slave never answers a beat that was not strobed
	a_term_owed: assert property (@(posedge i_axi_clk) disable iff (i_reset)
		w_term |-> (r_inflight != '0));

endmodule
